// ==== common/spectrumPkg.sv ====
`ifndef SPECTRUM_PKG_SV
`define SPECTRUM_PKG_SV

package spectrumPkg;

	// 640x480 raster, all counts in pixel clocks or lines
	localparam logic [9:0] H_ACTIVE = 10'd640;
	localparam logic [9:0] H_FRONT = 10'd16;
	localparam logic [9:0] H_SYNC = 10'd96;
	localparam logic [9:0] H_BACK = 10'd48;
	localparam logic [9:0] H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK; // 800
	localparam logic [9:0] V_ACTIVE = 10'd480;
	localparam logic [9:0] V_FRONT = 10'd10;
	localparam logic [9:0] V_SYNC = 10'd2;
	localparam logic [9:0] V_BACK = 10'd33;
	localparam logic [9:0] V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK; // 525

	localparam int NUM_BANDS = 8;
	localparam int NUM_LEVELS = 5;
	localparam int POWER_BITS = 11;
	localparam int LAYER_BITS = 6;

	// bar grid geometry
	localparam logic [9:0] BAND_PITCH = 10'd80;
	localparam logic [9:0] BAR_LEFT = 10'd8; // centers a block in its band
	localparam logic [9:0] BLOCK_WIDTH = 10'd64;
	localparam logic [9:0] LEVEL_PITCH = 10'd96;
	localparam logic [9:0] BLOCK_HEIGHT = 10'd88;

	localparam int THRESHOLD_SHIFT = 6; // level 0 lights above 64

	// half intensity palette, a lit block doubles each channel
	localparam int NUM_COLORS = 13;
	localparam logic [23:0] PALETTE [NUM_COLORS] = '{
		{8'd20, 8'd20, 8'd20}, // white
		{8'd20, 8'd0, 8'd0}, // red
		{8'd22, 8'd4, 8'd4}, // brick
		{8'd31, 8'd21, 8'd0}, // orange
		{8'd31, 8'd31, 8'd0}, // yellow
		{8'd30, 8'd29, 8'd17}, // khaki
		{8'd14, 8'd17, 8'd5}, // olive
		{8'd7, 8'd26, 8'd7}, // lime
		{8'd5, 8'd18, 8'd5}, // green
		{8'd8, 8'd28, 8'd26}, // aqua
		{8'd0, 8'd17, 8'd17}, // cyan
		{8'd4, 8'd18, 8'd31}, // light blue
		{8'd8, 8'd13, 8'd28} // blue
	};

	// palette entry per level, bottom to top
	localparam int LEVEL_COLOR [NUM_LEVELS] = '{7, 4, 3, 2, 1};

	localparam logic [23:0] BACKGROUND = 24'd0;

	typedef enum logic {
		IDLE,
		ACK
	} busState_t;

	function automatic logic [23:0] paletteColor(input int entry);
		if (entry < 0 || entry >= NUM_COLORS) begin
			return PALETTE[NUM_COLORS - 1]; // out of range falls back to blue
		end
		return PALETTE[entry];
	endfunction

endpackage

`endif

// ==== design/rasterTiming.sv ====
module rasterTiming (
	input  logic       clk,
	input  logic       reset,
	output logic [9:0] pixelX,
	output logic [9:0] pixelY,
	output logic       hsync,
	output logic       vsync,
	output logic       displayEnable,
	output logic       frameStart
);
	import spectrumPkg::*;

	localparam logic [9:0] H_LAST = H_TOTAL - 10'd1;
	localparam logic [9:0] V_LAST = V_TOTAL - 10'd1;
	localparam logic [9:0] H_SYNC_START = H_ACTIVE + H_FRONT;
	localparam logic [9:0] H_SYNC_END = H_SYNC_START + H_SYNC;
	localparam logic [9:0] V_SYNC_START = V_ACTIVE + V_FRONT;
	localparam logic [9:0] V_SYNC_END = V_SYNC_START + V_SYNC;

	logic [9:0] hCount;
	logic [9:0] vCount;

	always_ff @(posedge clk) begin
		if (reset) begin
			hCount <= '0;
			vCount <= '0;
		end else if (hCount == H_LAST) begin
			hCount <= '0; // end of line
			if (vCount == V_LAST) begin
				vCount <= '0;
			end else begin
				vCount <= vCount + 10'd1;
			end
		end else begin
			hCount <= hCount + 10'd1;
		end
	end

	assign pixelX = hCount;
	assign pixelY = vCount;

	// syncs are active low
	assign hsync = !((hCount >= H_SYNC_START) && (hCount < H_SYNC_END));
	assign vsync = !((vCount >= V_SYNC_START) && (vCount < V_SYNC_END));

	assign displayEnable = (hCount < H_ACTIVE) && (vCount < V_ACTIVE);
	assign frameStart = (hCount == 10'd0) && (vCount == 10'd0);

	pixelXInRange: assert property (@(posedge clk) disable iff (reset) pixelX <= H_LAST)
		else $error("pixelX beyond end of line: %0d", pixelX);

endmodule

// ==== design/wbPowerRegs.sv ====
module wbPowerRegs (
	input  logic                                                   clk,
	input  logic                                                   reset,
	input  logic                                                   cyc,
	input  logic                                                   stb,
	input  logic                                                   we,
	input  logic [2:0]                                             adr,
	input  logic [spectrumPkg::POWER_BITS-1:0]                     writeData,
	input  logic                                                   frameStart,
	output logic                                                   ack,
	output logic [spectrumPkg::POWER_BITS-1:0]                     readData,
	output logic [spectrumPkg::NUM_BANDS*spectrumPkg::POWER_BITS-1:0] framePower
);
	import spectrumPkg::*;

	busState_t state;
	logic [POWER_BITS-1:0] livePower [NUM_BANDS];

	// one ack per strobe, then wait for stb to drop
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			ack <= 1'b0;
			for (int b = 0; b < NUM_BANDS; b++) begin
				livePower[b] <= '0;
			end
		end else begin
			case (state)
				IDLE: begin
					if (cyc && stb) begin
						ack <= 1'b1;
						state <= ACK;
						if (we) begin
							livePower[adr] <= writeData; // visible during the ack cycle
						end
					end
				end
				ACK: begin
					ack <= 1'b0;
					if (!stb) begin
						state <= IDLE;
					end
				end
				default: begin
					ack <= 1'b0;
					state <= IDLE;
				end
			endcase
		end
	end

	assign readData = livePower[adr]; // live value, not the shadow

	// shadow set only moves at the first pixel of a frame
	always_ff @(posedge clk) begin
		if (reset) begin
			framePower <= '0;
		end else if (frameStart) begin
			for (int b = 0; b < NUM_BANDS; b++) begin
				framePower[b*POWER_BITS +: POWER_BITS] <= livePower[b];
			end
		end
	end

	ackInsideCycle: assert property (@(posedge clk) disable iff (reset) ack |-> (cyc && stb))
		else $error("ack raised outside a bus cycle");

endmodule

// ==== bars/colorBlock.sv ====
module colorBlock #(
	parameter logic [9:0] topLeftX = 10'd0,
	parameter logic [9:0] topLeftY = 10'd0,
	parameter logic [9:0] blockWidth = 10'd64,
	parameter logic [9:0] blockHeight = 10'd88,
	parameter int layer = 0,
	parameter int color = 0,
	parameter int level = 0
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [spectrumPkg::POWER_BITS-1:0] power,
	input  logic [9:0]                          pixelX,
	input  logic [9:0]                          pixelY,
	output logic [spectrumPkg::LAYER_BITS-1:0] oLayer,
	output logic                                oVal,
	output logic [7:0]                          R,
	output logic [7:0]                          G,
	output logic [7:0]                          B
);
	import spectrumPkg::*;

	localparam logic [10:0] RIGHT_EDGE = 11'(topLeftX) + 11'(blockWidth);
	localparam logic [10:0] BOTTOM_EDGE = 11'(topLeftY) + 11'(blockHeight);
	localparam logic [23:0] BASE = paletteColor(color);
	localparam logic [23:0] BRIGHT = {BASE[22:16], 1'b0, BASE[14:8], 1'b0, BASE[6:0], 1'b0};
	localparam logic [POWER_BITS:0] THRESHOLD =
		(POWER_BITS + 1)'(1 << (level + THRESHOLD_SHIFT));

	logic insideX;
	logic insideY;
	logic lit;
	logic [23:0] shownColor;

	// edges themselves are outside
	assign insideX = (pixelX > topLeftX) && ({1'b0, pixelX} < RIGHT_EDGE);
	assign insideY = (pixelY > topLeftY) && ({1'b0, pixelY} < BOTTOM_EDGE);

	assign lit = {1'b0, power} > THRESHOLD; // strictly above
	assign shownColor = lit ? BRIGHT : BASE;

	assign oLayer = LAYER_BITS'(layer);

	always_ff @(posedge clk) begin
		if (reset) begin
			oVal <= 1'b0;
		end else begin
			oVal <= insideX && insideY;
		end
	end

	always_ff @(posedge clk) begin
		R <= shownColor[23:16];
		G <= shownColor[15:8];
		B <= shownColor[7:0];
	end

endmodule

// ==== bars/barColumn.sv ====
module barColumn #(
	parameter int band = 0
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [spectrumPkg::POWER_BITS-1:0] power,
	input  logic [9:0]                          pixelX,
	input  logic [9:0]                          pixelY,
	output logic                                colVal,
	output logic [spectrumPkg::LAYER_BITS-1:0] colLayer,
	output logic [23:0]                         colRGB
);
	import spectrumPkg::*;

	localparam logic [9:0] LEFT_X = 10'(band * BAND_PITCH + BAR_LEFT);
	localparam int TOP_MARGIN = (LEVEL_PITCH - BLOCK_HEIGHT) / 2; // 4 lines

	logic [NUM_LEVELS-1:0] levelVal;
	logic [LAYER_BITS-1:0] levelLayer [NUM_LEVELS];
	logic [23:0] levelRGB [NUM_LEVELS];

	for (genvar l = 0; l < NUM_LEVELS; l++) begin : gLevel
		colorBlock #(
			.topLeftX(LEFT_X),
			.topLeftY(10'(V_ACTIVE - (l + 1) * LEVEL_PITCH + TOP_MARGIN)),
			.blockWidth(BLOCK_WIDTH),
			.blockHeight(BLOCK_HEIGHT),
			.layer(l),
			.color(LEVEL_COLOR[l]),
			.level(l)
		) uBlock (
			.clk(clk),
			.reset(reset),
			.power(power),
			.pixelX(pixelX),
			.pixelY(pixelY),
			.oLayer(levelLayer[l]),
			.oVal(levelVal[l]),
			.R(levelRGB[l][23:16]),
			.G(levelRGB[l][15:8]),
			.B(levelRGB[l][7:0])
		);
	end

	// later levels carry higher layers and win
	always_comb begin
		colLayer = '0;
		colRGB = BACKGROUND;
		for (int l = 0; l < NUM_LEVELS; l++) begin
			if (levelVal[l]) begin
				colLayer = levelLayer[l];
				colRGB = levelRGB[l];
			end
		end
	end

	assign colVal = |levelVal;

	noOverlap: assert property (@(posedge clk) disable iff (reset) $onehot0(levelVal))
		else $error("band %0d has overlapping valid blocks", band);

endmodule

// ==== design/layerMixer.sv ====
module layerMixer (
	input  logic                                                    clk,
	input  logic                                                    reset,
	input  logic [spectrumPkg::NUM_BANDS-1:0]                       bandVal,
	input  logic [spectrumPkg::NUM_BANDS*spectrumPkg::LAYER_BITS-1:0] bandLayer,
	input  logic [spectrumPkg::NUM_BANDS*24-1:0]                    bandRGB,
	input  logic                                                    hsyncIn,
	input  logic                                                    vsyncIn,
	input  logic                                                    deIn,
	output logic [7:0]                                              red,
	output logic [7:0]                                              green,
	output logic [7:0]                                              blue,
	output logic                                                    hsync,
	output logic                                                    vsync,
	output logic                                                    de
);
	import spectrumPkg::*;

	logic found;
	logic [LAYER_BITS-1:0] bestLayer;
	logic [23:0] pickRGB;
	logic hsyncD1;
	logic vsyncD1;
	logic deD1;

	// strict compare keeps the lower band on a tie
	always_comb begin
		found = 1'b0;
		bestLayer = '0;
		pickRGB = BACKGROUND;
		for (int b = 0; b < NUM_BANDS; b++) begin
			if (bandVal[b] && (!found || (bandLayer[b*LAYER_BITS +: LAYER_BITS] > bestLayer))) begin
				found = 1'b1;
				bestLayer = bandLayer[b*LAYER_BITS +: LAYER_BITS];
				pickRGB = bandRGB[b*24 +: 24];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			hsyncD1 <= 1'b1; // syncs idle high
			vsyncD1 <= 1'b1;
			deD1 <= 1'b0;
			hsync <= 1'b1;
			vsync <= 1'b1;
			de <= 1'b0;
			red <= '0;
			green <= '0;
			blue <= '0;
		end else begin
			hsyncD1 <= hsyncIn;
			vsyncD1 <= vsyncIn;
			deD1 <= deIn; // lines up with the block outputs
			hsync <= hsyncD1;
			vsync <= vsyncD1;
			de <= deD1;
			if (deD1) begin
				red <= pickRGB[23:16];
				green <= pickRGB[15:8];
				blue <= pickRGB[7:0];
			end else begin
				red <= '0; // blanking
				green <= '0;
				blue <= '0;
			end
		end
	end

endmodule

// ==== design/spectrumDisplay.sv ====
module spectrumDisplay (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               cyc,
	input  logic                               stb,
	input  logic                               we,
	input  logic [2:0]                         adr,
	input  logic [spectrumPkg::POWER_BITS-1:0] writeData,
	output logic                               ack,
	output logic [spectrumPkg::POWER_BITS-1:0] readData,
	output logic [7:0]                         red,
	output logic [7:0]                         green,
	output logic [7:0]                         blue,
	output logic                               hsync,
	output logic                               vsync,
	output logic                               de
);
	import spectrumPkg::*;

	logic [9:0] pixelX;
	logic [9:0] pixelY;
	logic rasterHsync;
	logic rasterVsync;
	logic displayEnable;
	logic frameStart;
	logic [NUM_BANDS*POWER_BITS-1:0] framePower;
	logic [NUM_BANDS-1:0] bandVal;
	logic [NUM_BANDS*LAYER_BITS-1:0] bandLayer;
	logic [NUM_BANDS*24-1:0] bandRGB;

	rasterTiming uTiming (
		.clk(clk),
		.reset(reset),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.hsync(rasterHsync),
		.vsync(rasterVsync),
		.displayEnable(displayEnable),
		.frameStart(frameStart)
	);

	wbPowerRegs uRegs (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.writeData(writeData),
		.frameStart(frameStart),
		.ack(ack),
		.readData(readData),
		.framePower(framePower)
	);

	for (genvar b = 0; b < NUM_BANDS; b++) begin : gBand
		barColumn #(
			.band(b)
		) uColumn (
			.clk(clk),
			.reset(reset),
			.power(framePower[b*POWER_BITS +: POWER_BITS]),
			.pixelX(pixelX),
			.pixelY(pixelY),
			.colVal(bandVal[b]),
			.colLayer(bandLayer[b*LAYER_BITS +: LAYER_BITS]),
			.colRGB(bandRGB[b*24 +: 24])
		);
	end

	// two cycles from counter to pins
	layerMixer uMixer (
		.clk(clk),
		.reset(reset),
		.bandVal(bandVal),
		.bandLayer(bandLayer),
		.bandRGB(bandRGB),
		.hsyncIn(rasterHsync),
		.vsyncIn(rasterVsync),
		.deIn(displayEnable),
		.red(red),
		.green(green),
		.blue(blue),
		.hsync(hsync),
		.vsync(vsync),
		.de(de)
	);

endmodule

// ==== sim/spectrumDisplay_tb.sv ====
module spectrumDisplay_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import spectrumPkg::*;

	logic clk;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	logic [2:0] adr;
	logic [POWER_BITS-1:0] writeData;
	logic ack;
	logic [POWER_BITS-1:0] readData;
	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;
	logic hsync;
	logic vsync;
	logic de;

	logic [POWER_BITS-1:0] liveModel [NUM_BANDS]; // what the host has written
	logic [POWER_BITS-1:0] shownPower [NUM_BANDS]; // powers of the frame on screen
	logic [31:0] lfsr;
	string testName;
	int lineIdx;
	int xPos;
	int vsyncFalls;
	int hLow;
	int vLow;
	logic deLast;
	logic vsyncLast;
	logic ackSeen;
	logic [23:0] actRGB;
	logic [23:0] expRGB;
	int pixelErrors = 0;
	int syncErrors = 0;
	int busErrors = 0;
	int resetErrors = 0;

	spectrumDisplay dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// expected pixel at active position x,y from the grid rules
	function automatic logic [23:0] expectedPixel(input int x, input int y);
		int band;
		int left;
		int top;
		logic [23:0] base;
		band = x / int'(BAND_PITCH);
		left = band * int'(BAND_PITCH) + int'(BAR_LEFT);
		if (x <= left || x >= left + int'(BLOCK_WIDTH)) begin
			return BACKGROUND;
		end
		for (int l = 0; l < NUM_LEVELS; l++) begin
			top = int'(V_ACTIVE) - (l + 1) * int'(LEVEL_PITCH) + 4;
			if (y > top && y < top + int'(BLOCK_HEIGHT)) begin
				base = PALETTE[LEVEL_COLOR[l]];
				if (int'(shownPower[band]) > (1 << (l + THRESHOLD_SHIFT))) begin
					return {base[23:16] << 1, base[15:8] << 1, base[7:0] << 1};
				end
				return base;
			end
		end
		return BACKGROUND;
	endfunction

	// raster position recovered from de and vsync between edges
	always @(negedge clk) begin
		if (reset) begin
			lineIdx = -1;
			xPos = 0;
			vsyncFalls = 0;
			hLow = 0;
			vLow = 0;
			deLast = 1'b0;
			vsyncLast = 1'b1;
			ackSeen = 1'b0;
			actRGB = '0;
			expRGB = '0;
		end else begin
			ackSeen = ack;
			if (vsyncLast && !vsync) begin
				assert (lineIdx + 1 == int'(V_ACTIVE)) else begin
					syncErrors++;
					$display("** Error [%s] active lines: expected %0d, actual %0d",
						testName, int'(V_ACTIVE), lineIdx + 1);
				end
				lineIdx = -1;
				vsyncFalls++;
			end
			if (de && !deLast) begin
				lineIdx++;
				xPos = 0;
				if (lineIdx == 0) begin
					shownPower = liveModel; // shadow copy at frame start
				end
			end else if (de) begin
				xPos++;
			end
			if (!de && deLast) begin
				assert (xPos + 1 == int'(H_ACTIVE)) else begin
					syncErrors++;
					$display("** Error [%s] de width: expected %0d, actual %0d",
						testName, int'(H_ACTIVE), xPos + 1);
				end
			end
			actRGB = {red, green, blue};
			expRGB = (de && lineIdx >= 0) ? expectedPixel(xPos, lineIdx) : 24'd0;
			if (!hsync) begin
				hLow++;
			end else if (hLow != 0) begin
				assert (hLow == int'(H_SYNC)) else begin
					syncErrors++;
					$display("** Error [%s] hsync width: expected %0d, actual %0d",
						testName, int'(H_SYNC), hLow);
				end
				hLow = 0;
			end
			if (!vsync) begin
				vLow++;
			end else if (vLow != 0) begin
				assert (vLow == int'(V_SYNC) * int'(H_TOTAL)) else begin
					syncErrors++;
					$display("** Error [%s] vsync width: expected %0d, actual %0d",
						testName, int'(V_SYNC) * int'(H_TOTAL), vLow);
				end
				vLow = 0;
			end
			deLast = de;
			vsyncLast = vsync;
		end
	end

	pixelMatches: assert property (@(posedge clk) disable iff (reset) actRGB == expRGB)
		else begin
			pixelErrors++;
			if (pixelErrors <= 20) begin
				$display("** Error [%s] pixel %0d,%0d: expected %h, actual %h",
					testName, xPos, lineIdx, expRGB, actRGB);
			end
		end

	ackOnce: assert property (@(posedge clk) disable iff (reset) ackSeen |=> !ackSeen)
		else begin
			busErrors++;
			$display("ack stayed high for more than one cycle");
		end

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$finish;
	endtask

	// one classic cycle with stb held over the ack edge
	task automatic busTransfer(input logic isWrite, input logic [2:0] band,
			input logic [POWER_BITS-1:0] value, output logic [POWER_BITS-1:0] data);
		int waited;
		cyc = 1'b1;
		stb = 1'b1;
		we = isWrite;
		adr = band;
		writeData = value;
		waited = 0;
		@(negedge clk);
		while (!ack && waited < 16) begin
			@(negedge clk);
			waited++;
		end
		if (!ack) begin
			abortRun("the bus slave gave no ack within 16 cycles");
		end
		data = readData;
		@(negedge clk);
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		@(negedge clk);
	endtask

	task automatic writePower(input logic [2:0] band, input logic [POWER_BITS-1:0] value);
		logic [POWER_BITS-1:0] unused;
		busTransfer(1'b1, band, value, unused);
		liveModel[band] = value;
	endtask

	task automatic readBack(input logic [2:0] band);
		logic [POWER_BITS-1:0] got;
		busTransfer(1'b0, band, '0, got);
		assert (got == liveModel[band]) else begin
			busErrors++;
			$display("** Error [%s] band %0d: expected %h, actual %h",
				testName, band, liveModel[band], got);
		end
	endtask

	task automatic waitFrameEnd();
		int start;
		int waited;
		start = vsyncFalls;
		waited = 0;
		while (vsyncFalls == start && waited < 2 * int'(H_TOTAL) * int'(V_TOTAL)) begin
			@(posedge clk);
			waited++;
		end
		if (vsyncFalls == start) begin
			abortRun("vsync never fell, the raster looks stuck");
		end
		@(negedge clk);
	endtask

	task automatic waitLine(input int line);
		int waited;
		waited = 0;
		while (lineIdx != line && waited < 2 * int'(H_TOTAL) * int'(V_TOTAL)) begin
			@(posedge clk);
			waited++;
		end
		if (lineIdx != line) begin
			abortRun("the wanted active line never came");
		end
		@(negedge clk);
	endtask

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32,22,2,1
	endfunction

	task automatic nextRandomPower(output logic [POWER_BITS-1:0] value);
		value = '0;
		for (int i = 0; i < POWER_BITS; i++) begin
			lfsr = lfsrStep(lfsr);
			value = {value[POWER_BITS-2:0], lfsr[0]};
		end
	endtask

	initial begin
		logic [POWER_BITS-1:0] value;
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		writeData = '0;
		lfsr = 32'h132e28a2;
		testName = "reset";
		for (int b = 0; b < NUM_BANDS; b++) begin
			liveModel[b] = '0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		assert (!ack && !de && {red, green, blue} == 24'd0 && hsync && vsync) else begin
			resetErrors++;
			$display("outputs are not in their idle state after reset");
		end
		testName = "static";
		waitFrameEnd();
		testName = "readback";
		for (int b = 0; b < NUM_BANDS; b++) begin
			writePower(3'(b), 11'(b * 251 + 17));
		end
		for (int b = 0; b < NUM_BANDS; b++) begin
			readBack(3'(b));
		end
		waitFrameEnd();
		testName = "threshold above";
		for (int b = 0; b < NUM_LEVELS; b++) begin
			writePower(3'(b), 11'((1 << (b + THRESHOLD_SHIFT)) + 1));
		end
		for (int b = NUM_LEVELS; b < NUM_BANDS; b++) begin
			writePower(3'(b), 11'(1 << (b + 1))); // exactly at levels 0 to 2
		end
		waitFrameEnd();
		testName = "threshold at";
		for (int b = 0; b < NUM_LEVELS; b++) begin
			writePower(3'(b), 11'(1 << (b + THRESHOLD_SHIFT)));
		end
		writePower(3'd5, 11'd512);
		writePower(3'd6, 11'd1024);
		writePower(3'd7, 11'd2047);
		waitLine(240);
		testName = "alignment";
		writePower(3'd3, 11'd0); // lower blocks of band 3 must stay lit this frame
		waitFrameEnd();
		waitFrameEnd();
		testName = "random";
		for (int b = 0; b < NUM_BANDS; b++) begin
			nextRandomPower(value);
			writePower(3'(b), value);
		end
		waitFrameEnd();
		$display("error counts: reset %0d, bus %0d, sync %0d, pixel %0d",
			resetErrors, busErrors, syncErrors, pixelErrors);
		if (resetErrors + busErrors + syncErrors + pixelErrors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== spectrumDisplay.f ====
common/spectrumPkg.sv
design/rasterTiming.sv
design/wbPowerRegs.sv
bars/colorBlock.sv
bars/barColumn.sv
design/layerMixer.sv
design/spectrumDisplay.sv
sim/spectrumDisplay_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--timescale 1ns/100ps \
	--top-module spectrumDisplay_tb \
	-f spectrumDisplay.f \
	-o simv

output="$(./obj_dir/simv)" || true
echo "$output"

if echo "$output" | grep -qx "TEST PASSED"; then
	exit 0
fi
exit 1
